// File: rtl/ex_ctrl_pkg.sv
package ex_ctrl_pkg;

    // Execute unit select, 2'b10 is reserved
    typedef enum logic [1:0] {
        UNIT_ALU = 2'b00,
        UNIT_MDU = 2'b01,
        UNIT_CSR = 2'b11
    } unit_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SUB    = 4'b0001,
        ALU_SLL    = 4'b0011,
        ALU_SLT    = 4'b0100,
        ALU_SLTU   = 4'b0101,
        ALU_XOR    = 4'b0110,
        ALU_SRL    = 4'b0111,
        ALU_SRA    = 4'b1000,
        ALU_OR     = 4'b1001,
        ALU_AND    = 4'b1010,
        ALU_PASS_B = 4'b1100
    } alu_op_e;

    // Same coding as the M-extension funct3
    typedef enum logic [2:0] {
        MDU_MUL    = 3'b000,
        MDU_MULH   = 3'b001,
        MDU_MULHSU = 3'b010,
        MDU_MULHU  = 3'b011,
        MDU_DIV    = 3'b100,
        MDU_DIVU   = 3'b101,
        MDU_REM    = 3'b110,
        MDU_REMU   = 3'b111
    } mdu_op_e;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'b00,
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        PJ_NONE   = 2'b00,
        PJ_MRET   = 2'b01,
        PJ_ECALL  = 2'b10,
        PJ_EBREAK = 2'b11
    } privjump_e;

    typedef enum logic [1:0] {
        WB_ALU  = 2'b00,
        WB_LOAD = 2'b01,
        WB_PC4  = 2'b11
    } wb_sel_e;

    typedef struct packed {
        logic      legal;
        unit_sel_e unit;
        logic      csr_en;
        csr_op_e   csr_op;
        logic      csr_imm_sel;
        privjump_e privjump;
        alu_op_e   alu_op;
        logic      mdu_en;
        mdu_op_e   mdu_op;
        logic      rs2_negate;
        logic      reg_wr_en;
        wb_sel_e   wb_sel;
        logic      op1_pc_sel;
        logic      op2_imm_sel;
        logic      is_load;
        logic      is_store;
    } ex_ctrl_t;

endpackage

// File: rtl/ex_ctrl_stage.sv
`timescale 1ns/1ps

module ex_ctrl_stage (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  fields_valid_i,
    input  ex_ctrl_pkg::ex_ctrl_t int_ctrl_i,
    input  logic                  int_hit_i,
    input  ex_ctrl_pkg::ex_ctrl_t sys_ctrl_i,
    input  logic                  sys_hit_i,
    output logic                  ctrl_valid_o,
    output ex_ctrl_pkg::ex_ctrl_t ctrl_o
);
    import ex_ctrl_pkg::*;

    ex_ctrl_t ctrl_d;

    // Illegal encodings leave the whole bundle at zero
    always_comb begin
        if (int_hit_i) begin
            ctrl_d = int_ctrl_i;
        end else if (sys_hit_i) begin
            ctrl_d = sys_ctrl_i;
        end else begin
            ctrl_d = '0;
        end
        ctrl_d.legal = int_hit_i | sys_hit_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ctrl_valid_o <= 1'b0;
            ctrl_o       <= '0;
        end else begin
            ctrl_valid_o <= fields_valid_i;
            if (fields_valid_i) begin
                ctrl_o <= ctrl_d;
            end
        end
    end

    // Decoders own disjoint opcode sets
    hits_exclusive_a: assert property (
        @(posedge clk_i) disable iff (rst_i)
        fields_valid_i |-> !(int_hit_i && sys_hit_i)
    ) else $error("integer and system decoders both hit");

endmodule

// File: rtl/ex_decoder_top.sv
`timescale 1ns/1ps

module ex_decoder_top (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  instr_valid_i,
    input  riscv_isa_pkg::instr_t instr_i,
    output logic                  ctrl_valid_o,
    output ex_ctrl_pkg::ex_ctrl_t ctrl_o
);
    import riscv_isa_pkg::*;
    import ex_ctrl_pkg::*;

    logic          fields_valid;
    instr_fields_t fields;
    ex_ctrl_t      int_ctrl;
    logic          int_hit;
    ex_ctrl_t      sys_ctrl;
    logic          sys_hit;

    instr_capture u_instr_capture (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .fields_valid_o (fields_valid),
        .fields_o       (fields)
    );

    int_decoder u_int_decoder (
        .fields_i (fields),
        .ctrl_o   (int_ctrl),
        .hit_o    (int_hit)
    );

    system_decoder u_system_decoder (
        .fields_i (fields),
        .ctrl_o   (sys_ctrl),
        .hit_o    (sys_hit)
    );

    ex_ctrl_stage u_ex_ctrl_stage (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .fields_valid_i (fields_valid),
        .int_ctrl_i     (int_ctrl),
        .int_hit_i      (int_hit),
        .sys_ctrl_i     (sys_ctrl),
        .sys_hit_i      (sys_hit),
        .ctrl_valid_o   (ctrl_valid_o),
        .ctrl_o         (ctrl_o)
    );

endmodule

// File: rtl/instr_capture.sv
`timescale 1ns/1ps

module instr_capture (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         instr_valid_i,
    input  riscv_isa_pkg::instr_t        instr_i,
    output logic                         fields_valid_o,
    output riscv_isa_pkg::instr_fields_t fields_o
);
    import riscv_isa_pkg::*;

    instr_t instr_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fields_valid_o <= 1'b0;
        end else begin
            fields_valid_o <= instr_valid_i;
        end
    end

    // Word held until the next strobe
    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            instr_q <= instr_i;
        end
    end

    always_comb begin
        fields_o.opcode  = instr_q[6:2];
        fields_o.funct3  = instr_q[14:12];
        fields_o.funct7  = instr_q[31:25];
        fields_o.funct12 = instr_q[31:20];
        fields_o.rd      = instr_q[11:7];
        fields_o.rs1     = instr_q[19:15];
        fields_o.rs2     = instr_q[24:20];
    end

endmodule

// File: rtl/int_decoder.sv
`timescale 1ns/1ps

module int_decoder (
    input  riscv_isa_pkg::instr_fields_t fields_i,
    output ex_ctrl_pkg::ex_ctrl_t        ctrl_o,
    output logic                         hit_o
);
    import riscv_isa_pkg::*;
    import ex_ctrl_pkg::*;

    alu_op_e f3_alu_op;

    // ALU op from funct3, right shifts split by funct7
    always_comb begin
        case (fields_i.funct3)
            F3_ADD:  f3_alu_op = ALU_ADD;
            F3_SLL:  f3_alu_op = ALU_SLL;
            F3_SLT:  f3_alu_op = ALU_SLT;
            F3_SLTU: f3_alu_op = ALU_SLTU;
            F3_XOR:  f3_alu_op = ALU_XOR;
            F3_SR:   f3_alu_op = (fields_i.funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            F3_OR:   f3_alu_op = ALU_OR;
            F3_AND:  f3_alu_op = ALU_AND;
            default: f3_alu_op = ALU_ADD;
        endcase
    end

    always_comb begin
        ctrl_o = '0;
        hit_o  = 1'b0;
        case (fields_i.opcode)
            OPC_LOAD: begin
                hit_o              = 1'b1;
                ctrl_o.alu_op      = ALU_ADD;
                ctrl_o.reg_wr_en   = 1'b1;
                ctrl_o.wb_sel      = WB_LOAD;
                ctrl_o.op2_imm_sel = 1'b1;
                ctrl_o.is_load     = 1'b1;
            end
            OPC_STORE: begin
                hit_o              = 1'b1;
                ctrl_o.alu_op      = ALU_ADD;
                ctrl_o.op2_imm_sel = 1'b1;
                ctrl_o.is_store    = 1'b1;
            end
            OPC_BRANCH: begin
                // Adder forms the target, compare is done elsewhere
                hit_o              = 1'b1;
                ctrl_o.alu_op      = ALU_ADD;
                ctrl_o.op1_pc_sel  = 1'b1;
                ctrl_o.op2_imm_sel = 1'b1;
            end
            OPC_AUIPC: begin
                hit_o              = 1'b1;
                ctrl_o.alu_op      = ALU_ADD;
                ctrl_o.reg_wr_en   = 1'b1;
                ctrl_o.op1_pc_sel  = 1'b1;
                ctrl_o.op2_imm_sel = 1'b1;
            end
            OPC_JAL: begin
                hit_o              = 1'b1;
                ctrl_o.reg_wr_en   = 1'b1;
                ctrl_o.wb_sel      = WB_PC4;
                ctrl_o.op1_pc_sel  = 1'b1;
                ctrl_o.op2_imm_sel = 1'b1;
            end
            OPC_JALR: begin
                hit_o              = 1'b1;
                ctrl_o.reg_wr_en   = 1'b1;
                ctrl_o.wb_sel      = WB_PC4;
                ctrl_o.op2_imm_sel = 1'b1;
            end
            OPC_LUI: begin
                hit_o              = 1'b1;
                ctrl_o.alu_op      = ALU_PASS_B;
                ctrl_o.reg_wr_en   = 1'b1;
                ctrl_o.op2_imm_sel = 1'b1;
            end
            OPC_OP_IMM: begin
                // Shift amounts leave funct7 in the upper immediate bits
                case (fields_i.funct3)
                    F3_SLL:  hit_o = (fields_i.funct7 == F7_BASE);
                    F3_SR:   hit_o = (fields_i.funct7 == F7_BASE) || (fields_i.funct7 == F7_ALT);
                    default: hit_o = 1'b1;
                endcase
                if (hit_o) begin
                    ctrl_o.alu_op      = f3_alu_op;
                    ctrl_o.reg_wr_en   = 1'b1;
                    ctrl_o.op2_imm_sel = 1'b1;
                end
            end
            OPC_OP: begin
                case (fields_i.funct7)
                    F7_BASE: begin
                        hit_o            = 1'b1;
                        ctrl_o.alu_op    = f3_alu_op;
                        ctrl_o.reg_wr_en = 1'b1;
                    end
                    F7_ALT: begin
                        // Only SUB and SRA use the alternate encoding
                        if (fields_i.funct3 == F3_ADD) begin
                            hit_o             = 1'b1;
                            ctrl_o.alu_op     = ALU_SUB;
                            ctrl_o.rs2_negate = 1'b1;
                        end else if (fields_i.funct3 == F3_SR) begin
                            hit_o         = 1'b1;
                            ctrl_o.alu_op = ALU_SRA;
                        end
                        ctrl_o.reg_wr_en = hit_o;
                    end
                    F7_MULDIV: begin
                        hit_o            = 1'b1;
                        ctrl_o.unit      = UNIT_MDU;
                        ctrl_o.mdu_en    = 1'b1;
                        ctrl_o.mdu_op    = mdu_op_e'(fields_i.funct3);
                        ctrl_o.reg_wr_en = 1'b1;
                    end
                    default: hit_o = 1'b0;
                endcase
            end
            default: hit_o = 1'b0;
        endcase
    end

    // Bundle stays zero unless the decoder hit
    always_comb begin
        if (!hit_o) begin
            assert (ctrl_o == '0)
                else $error("integer bundle not zero without a hit");
        end
    end

endmodule

// File: rtl/riscv_isa_pkg.sv
package riscv_isa_pkg;

    // Instruction word with the two low bits removed
    typedef logic [31:2] instr_t;

    typedef logic [4:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [11:0] funct12_t;
    typedef logic [4:0]  reg_idx_t;

    typedef struct packed {
        opcode_t  opcode;
        funct3_t  funct3;
        funct7_t  funct7;
        funct12_t funct12;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } instr_fields_t;

    // Major opcodes, bits 6:2
    localparam opcode_t OPC_LOAD   = 5'b00000;
    localparam opcode_t OPC_STORE  = 5'b01000;
    localparam opcode_t OPC_BRANCH = 5'b11000;
    localparam opcode_t OPC_JALR   = 5'b11001;
    localparam opcode_t OPC_JAL    = 5'b11011;
    localparam opcode_t OPC_AUIPC  = 5'b00101;
    localparam opcode_t OPC_LUI    = 5'b01101;
    localparam opcode_t OPC_OP_IMM = 5'b00100;
    localparam opcode_t OPC_OP     = 5'b01100;
    localparam opcode_t OPC_SYSTEM = 5'b11100;

    localparam funct7_t F7_BASE   = 7'b0000000;
    localparam funct7_t F7_ALT    = 7'b0100000;
    localparam funct7_t F7_MULDIV = 7'b0000001;

    // Integer funct3, shared by OP and OP-IMM
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam funct3_t F3_PRIV   = 3'b000;
    localparam funct3_t F3_CSRRW  = 3'b001;
    localparam funct3_t F3_CSRRS  = 3'b010;
    localparam funct3_t F3_CSRRC  = 3'b011;
    localparam funct3_t F3_CSRRWI = 3'b101;
    localparam funct3_t F3_CSRRSI = 3'b110;
    localparam funct3_t F3_CSRRCI = 3'b111;

    localparam funct12_t F12_ECALL  = 12'h000;
    localparam funct12_t F12_EBREAK = 12'h001;
    localparam funct12_t F12_MRET   = 12'h302;
    localparam funct12_t F12_WFI    = 12'h105;

endpackage

// File: rtl/system_decoder.sv
`timescale 1ns/1ps

module system_decoder (
    input  riscv_isa_pkg::instr_fields_t fields_i,
    output ex_ctrl_pkg::ex_ctrl_t        ctrl_o,
    output logic                         hit_o
);
    import riscv_isa_pkg::*;
    import ex_ctrl_pkg::*;

    csr_op_e csr_op;

    // Register and immediate forms share the operation
    always_comb begin
        case (fields_i.funct3)
            F3_CSRRW, F3_CSRRWI: csr_op = CSR_WRITE;
            F3_CSRRS, F3_CSRRSI: csr_op = CSR_SET;
            F3_CSRRC, F3_CSRRCI: csr_op = CSR_CLEAR;
            default:             csr_op = CSR_NONE;
        endcase
    end

    always_comb begin
        ctrl_o = '0;
        hit_o  = 1'b0;
        if (fields_i.opcode == OPC_SYSTEM) begin
            if (csr_op != CSR_NONE) begin
                hit_o              = 1'b1;
                ctrl_o.unit        = UNIT_CSR;
                ctrl_o.csr_en      = 1'b1;
                ctrl_o.csr_op      = csr_op;
                ctrl_o.csr_imm_sel = fields_i.funct3[2];
                ctrl_o.reg_wr_en   = 1'b1;
            end else if (fields_i.funct3 == F3_PRIV && fields_i.rd == '0
                         && fields_i.rs1 == '0) begin
                case (fields_i.funct12)
                    F12_ECALL: begin
                        hit_o           = 1'b1;
                        ctrl_o.privjump = PJ_ECALL;
                    end
                    F12_EBREAK: begin
                        hit_o           = 1'b1;
                        ctrl_o.privjump = PJ_EBREAK;
                    end
                    F12_MRET: begin
                        hit_o           = 1'b1;
                        ctrl_o.privjump = PJ_MRET;
                    end
                    // WFI acts as a no-op here
                    F12_WFI: hit_o = 1'b1;
                    default: hit_o = 1'b0;
                endcase
            end
        end
    end

    // Bundle stays zero unless the decoder hit
    always_comb begin
        if (!hit_o) begin
            assert (ctrl_o == '0)
                else $error("system bundle not zero without a hit");
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module tb_ex_decoder -Mdir obj_dir \
    && ./obj_dir/Vtb_ex_decoder | tee /dev/stderr | grep -x "STATUS: PASS" > /dev/null \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }

// File: test/ex_decoder_ref.svh
`ifndef EX_DECODER_REF_SVH
`define EX_DECODER_REF_SVH

// Integer ALU operation selected by funct3
function automatic alu_op_e ref_alu(funct3_t f3, logic alt);
    case (f3)
        3'd0:    return ALU_ADD;
        3'd1:    return ALU_SLL;
        3'd2:    return ALU_SLT;
        3'd3:    return ALU_SLTU;
        3'd4:    return ALU_XOR;
        3'd5:    return alt ? ALU_SRA : ALU_SRL;
        3'd6:    return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

// Expected execute control bundle for one instruction word
function automatic ex_ctrl_t ref_decode(instr_t w);
    ex_ctrl_t c;
    opcode_t  opc;
    funct3_t  f3;
    funct7_t  f7;
    funct12_t f12;
    logic     ok;
    c   = '0;
    opc = w[6:2];
    f3  = w[14:12];
    f7  = w[31:25];
    f12 = w[31:20];
    ok  = 1'b1;
    case (opc)
        OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_AUIPC: begin
            c.alu_op      = ALU_ADD;
            c.op2_imm_sel = 1'b1;
            c.reg_wr_en   = (opc == OPC_LOAD) || (opc == OPC_AUIPC);
            c.wb_sel      = (opc == OPC_LOAD) ? WB_LOAD : WB_ALU;
            c.op1_pc_sel  = (opc == OPC_BRANCH) || (opc == OPC_AUIPC);
            c.is_load     = (opc == OPC_LOAD);
            c.is_store    = (opc == OPC_STORE);
        end
        OPC_JAL, OPC_JALR: begin
            c.reg_wr_en   = 1'b1;
            c.wb_sel      = WB_PC4;
            c.op1_pc_sel  = (opc == OPC_JAL);
            c.op2_imm_sel = 1'b1;
        end
        OPC_LUI: begin
            c.alu_op      = ALU_PASS_B;
            c.reg_wr_en   = 1'b1;
            c.op2_imm_sel = 1'b1;
        end
        OPC_OP_IMM: begin
            // Shift immediates must carry a valid funct7
            ok = (f3 != F3_SLL && f3 != F3_SR) || (f7 == F7_BASE)
                 || (f3 == F3_SR && f7 == F7_ALT);
            c.alu_op      = ref_alu(f3, f7 == F7_ALT);
            c.reg_wr_en   = 1'b1;
            c.op2_imm_sel = 1'b1;
        end
        OPC_OP: begin
            if (f7 == F7_MULDIV) begin
                c.unit   = UNIT_MDU;
                c.mdu_en = 1'b1;
                c.mdu_op = mdu_op_e'(f3);
            end else begin
                ok = (f7 == F7_BASE) || (f7 == F7_ALT && (f3 == F3_ADD || f3 == F3_SR));
                c.rs2_negate = (f7 == F7_ALT) && (f3 == F3_ADD);
                c.alu_op     = c.rs2_negate ? ALU_SUB : ref_alu(f3, f7 == F7_ALT);
            end
            c.reg_wr_en = 1'b1;
        end
        OPC_SYSTEM: begin
            if (f3 == F3_PRIV) begin
                ok = (w[11:7] == 5'd0) && (w[19:15] == 5'd0) && (f12 == F12_ECALL
                     || f12 == F12_EBREAK || f12 == F12_MRET || f12 == F12_WFI);
                c.privjump = (f12 == F12_ECALL)  ? PJ_ECALL  :
                             (f12 == F12_EBREAK) ? PJ_EBREAK :
                             (f12 == F12_MRET)   ? PJ_MRET   : PJ_NONE;
            end else begin
                ok            = (f3 != 3'd4);
                c.unit        = UNIT_CSR;
                c.csr_en      = 1'b1;
                // Low funct3 bits give write, set, clear
                c.csr_op      = csr_op_e'(f3[1:0]);
                c.csr_imm_sel = (f3 > 3'd4);
                c.reg_wr_en   = 1'b1;
            end
        end
        default: ok = 1'b0;
    endcase
    if (!ok) begin
        c = '0;
    end else begin
        c.legal = 1'b1;
    end
    return c;
endfunction

`endif

// File: test/tb_ex_decoder.sv
`timescale 1ns/1ps

module tb_ex_decoder;
    import riscv_isa_pkg::*;
    import ex_ctrl_pkg::*;

    `include "ex_decoder_ref.svh"

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 4;
    localparam logic [31:0] SEED         = 32'hf238bfc8;
    localparam int          N_PER_CLASS  = 4;
    localparam int          N_RANDOM     = 200;
    localparam int          N_STREAM     = 32;
    localparam int          MAX_GAP      = 3;
    localparam int          N_STROBES    = 7 * N_PER_CLASS + 19 + 8 + 13 + N_RANDOM + 6
                                           + 2 * N_STREAM;
    // Random gaps plus idle and drain cycles of the six tests
    localparam int          N_GAPS       = N_STREAM * MAX_GAP + 6 * 12;
    localparam int          WATCHDOG_NS  = (RESET_CYCLES + N_STROBES + N_GAPS) * CLK_PERIOD
                                           + 400;
    localparam opcode_t     PLAIN_OPC [7] = '{OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_AUIPC,
                                              OPC_JAL, OPC_JALR, OPC_LUI};

    logic     clk = 1'b0;
    logic     rst;
    logic     instr_valid;
    instr_t   instr_word;
    logic     ctrl_valid;
    ex_ctrl_t ctrl;

    int       cyc = 0;
    int       n_tests = 0;
    int       n_checks = 0;
    int       n_errors = 0;
    ex_ctrl_t exp_q [$];
    int       cyc_q [$];
    instr_t   word_q [$];
    logic     exp_valid;
    ex_ctrl_t exp_ctrl;
    instr_t   exp_word;

    ex_decoder_top DUT (
        .clk_i         (clk),
        .rst_i         (rst),
        .instr_valid_i (instr_valid),
        .instr_i       (instr_word),
        .ctrl_valid_o  (ctrl_valid),
        .ctrl_o        (ctrl)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc = cyc + 1;

    task automatic check_valid(logic exp, logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("MISMATCH ctrl_valid_o: expected %h, got %h", exp, act);
        end
    endtask

    task automatic check_ctrl(ex_ctrl_t exp, ex_ctrl_t act, string ctx);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("MISMATCH ctrl_o (%s): expected %h, got %h", ctx, exp, act);
        end
    endtask

    // Output strobe due exactly two cycles after its input strobe
    always @(negedge clk) begin
        if (!rst) begin
            exp_valid = (cyc_q.size() > 0) && (cyc_q[0] + 2 == cyc);
            check_valid(exp_valid, ctrl_valid);
            if (exp_valid) begin
                exp_ctrl = exp_q.pop_front();
                exp_word = word_q.pop_front();
                void'(cyc_q.pop_front());
                if (ctrl_valid) begin
                    check_ctrl(exp_ctrl, ctrl, $sformatf("instr %h", exp_word));
                end
            end
        end
    end

    function automatic instr_t rand_word();
        logic [31:0] r;
        r = $urandom();
        return r[31:2];
    endfunction

    function automatic instr_t any_word(opcode_t opc);
        instr_t w;
        w = rand_word();
        w[6:2] = opc;
        return w;
    endfunction

    function automatic instr_t i_type(funct3_t f3, opcode_t opc);
        instr_t w;
        w = any_word(opc);
        w[14:12] = f3;
        return w;
    endfunction

    function automatic instr_t r_type(funct7_t f7, funct3_t f3, opcode_t opc);
        instr_t w;
        w = i_type(f3, opc);
        w[31:25] = f7;
        return w;
    endfunction

    function automatic instr_t sys_word(funct12_t f12, reg_idx_t rs1, reg_idx_t rd);
        return {f12, rs1, F3_PRIV, rd, OPC_SYSTEM};
    endfunction

    task automatic send(instr_t w);
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr_word  = w;
        exp_q.push_back(ref_decode(w));
        cyc_q.push_back(cyc);
        word_q.push_back(w);
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
        end
    endtask

    task automatic finish_test(string name, int err_before);
        idle(1);
        while (cyc_q.size() != 0) @(negedge clk);
        n_tests++;
        $display("test %s: %0d errors", name, n_errors - err_before);
    endtask

    task automatic test_reset_idle();
        int errs;
        errs = n_errors;
        repeat (8) begin
            @(negedge clk);
            check_ctrl('0, ctrl, "idle after reset");
        end
        finish_test("reset_idle", errs);
    endtask

    task automatic test_rv32i();
        int errs;
        errs = n_errors;
        foreach (PLAIN_OPC[k]) begin
            repeat (N_PER_CLASS) send(any_word(PLAIN_OPC[k]));
        end
        for (int f = 0; f < 8; f++) begin
            if (f == 1 || f == 5) begin
                send(r_type(F7_BASE, funct3_t'(f), OPC_OP_IMM));
            end else begin
                send(i_type(funct3_t'(f), OPC_OP_IMM));
            end
            send(r_type(F7_BASE, funct3_t'(f), OPC_OP));
        end
        send(r_type(F7_ALT, F3_SR, OPC_OP_IMM));
        send(r_type(F7_ALT, F3_ADD, OPC_OP));
        send(r_type(F7_ALT, F3_SR, OPC_OP));
        finish_test("rv32i", errs);
    endtask

    task automatic test_mext();
        int errs;
        errs = n_errors;
        for (int f = 0; f < 8; f++) send(r_type(F7_MULDIV, funct3_t'(f), OPC_OP));
        finish_test("m_extension", errs);
    endtask

    task automatic test_system();
        int errs;
        errs = n_errors;
        // funct3 4 is reserved and must come out illegal
        for (int f = 1; f < 8; f++) send(i_type(funct3_t'(f), OPC_SYSTEM));
        send(sys_word(F12_ECALL, 5'd0, 5'd0));
        send(sys_word(F12_EBREAK, 5'd0, 5'd0));
        send(sys_word(F12_MRET, 5'd0, 5'd0));
        send(sys_word(F12_WFI, 5'd0, 5'd0));
        send(sys_word(F12_ECALL, 5'd3, 5'd0));
        send(sys_word(F12_ECALL, 5'd0, 5'd9));
        finish_test("system", errs);
    endtask

    task automatic test_random();
        int errs;
        errs = n_errors;
        repeat (N_RANDOM) send(rand_word());
        // Bit-manipulation rows: ANDN, ORN, SH1ADD, MIN, CLZ, BSETI
        send(r_type(7'b0100000, 3'b111, OPC_OP));
        send(r_type(7'b0100000, 3'b110, OPC_OP));
        send(r_type(7'b0010000, 3'b010, OPC_OP));
        send(r_type(7'b0000101, 3'b100, OPC_OP));
        send(r_type(7'b0110000, 3'b001, OPC_OP_IMM));
        send(r_type(7'b0010100, 3'b001, OPC_OP_IMM));
        finish_test("random", errs);
    endtask

    task automatic test_stream();
        int errs;
        errs = n_errors;
        for (int k = 0; k < N_STREAM; k++) begin
            send((k % 2 == 1) ? rand_word() : any_word(PLAIN_OPC[k % 7]));
        end
        for (int k = 0; k < N_STREAM; k++) begin
            send((k % 2 == 1) ? rand_word() : any_word(PLAIN_OPC[k % 7]));
            idle($urandom_range(MAX_GAP, 0));
        end
        finish_test("stream", errs);
    endtask

    initial begin
        void'($urandom(SEED));
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr_word  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_idle();
        test_rv32i();
        test_mext();
        test_system();
        test_random();
        test_stream();
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+test
rtl/riscv_isa_pkg.sv
rtl/ex_ctrl_pkg.sv
rtl/instr_capture.sv
rtl/int_decoder.sv
rtl/system_decoder.sv
rtl/ex_ctrl_stage.sv
rtl/ex_decoder_top.sv
test/tb_ex_decoder.sv
